// File: list.f
+incdir+.
acc_cpu_isa_pkg.sv
acc_cpu_ctrl_pkg.sv
scan_state_reg.sv
control_unit.sv
alu.sv
data_memory.sv
datapath.sv
acc_cpu_top.sv
acc_cpu_assert.sv
tb_acc_cpu.sv

// File: Makefile
TB := tb_acc_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module acc_cpu_top

sim:
	verilator --binary --timing -f list.f --top-module $(TB)
	-./obj_dir/V$(TB) > sim.log 2>&1
	cat sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_acc_cpu.sv
`timescale 1ns/1ps
`include "acc_cpu_consts.svh"

module tb_acc_cpu;

  localparam int NUM_PROGS = 40;
  localparam int MAX_STEPS = 16;
  localparam int WATCHDOG_CYCLES = NUM_PROGS * (MAX_STEPS * 2 * 2 + 80);

  logic                   clk;
  logic                   rst;
  logic                   processor_enable;
  logic                   scan_enable;
  logic                   scan_in;
  logic                   load_enable;
  logic [`ACC_ADDR_W-1:0] load_addr;
  logic [`ACC_DATA_W-1:0] load_data;
  logic [`ACC_ADDR_W-1:0] peek_addr;
  logic                   processor_halted;
  logic                   scan_out;
  logic [`ACC_DATA_W-1:0] peek_data;
  logic [`ACC_DATA_W-1:0] acc_value;

  logic [15:0]            lfsr = 16'd59884;
  logic [`ACC_DATA_W-1:0] prog [`ACC_MEM_DEPTH];
  logic [`ACC_DATA_W-1:0] model_mem [`ACC_MEM_DEPTH];
  logic [`ACC_DATA_W-1:0] model_acc;
  int                     jz_taken = 0;
  int                     jz_skipped = 0;
  int                     k;

  acc_cpu_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_byte(input string name, input logic [`ACC_DATA_W-1:0] exp,
                            input logic [`ACC_DATA_W-1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("CHECK FAILED %s: expected %02h actual %02h", name, exp, act));
    end
  endtask

  task automatic check_state(input string name, input acc_cpu_ctrl_pkg::cpu_state_e exp,
                             input acc_cpu_ctrl_pkg::cpu_state_e act);
    if (act !== exp) begin
      fail_run($sformatf("CHECK FAILED %s: expected %03b actual %03b", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("CHECK FAILED %s: expected %b actual %b", name, exp, act));
    end
  endtask

  // Galois LFSR, one step per bit handed out
  function automatic logic [7:0] rand_bits(input int count);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < count; i++) begin
      r = {r[6:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [7:0] alu_model(input logic [3:0] op, input logic [7:0] acc,
                                           input logic [7:0] imm);
    case (op)
      4'd0: return imm;
      4'd1: return acc + imm;
      4'd2: return acc - imm;
      4'd3: return ~acc;
      4'd4: return acc << 1;
      4'd5: return acc >> 1;
      4'd6: return acc + 8'd1;
      4'd7: return acc - 8'd1;
      default: return 8'd0; // CLR
    endcase
  endfunction

  // Code in 0..len-1, HLT at len and above up to 15, data bytes in 16..31
  task automatic make_program();
    int         len;
    logic [2:0] op;
    logic [4:0] field;
    logic [7:0] spare;
    len = 4 + int'(rand_bits(4)) % 11;
    for (int a = 0; a < `ACC_MEM_DEPTH; a++) begin
      prog[a] = (a < 16) ? `ACC_HALT_INSN : rand_bits(8);
    end
    for (int i = 0; i < len; i++) begin
      op = 3'(rand_bits(3));
      field = 5'(16 + int'(rand_bits(4)));
      if (op == 3'd2 || op == 3'd3) begin
        field = 5'(i + 1 + int'(rand_bits(4)) % (len - i)); // Forward targets only
      end else if (op == 3'd6) begin
        field[4:1] = 4'(int'(rand_bits(4)) % 9);
        spare = rand_bits(1);
        field[0] = spare[0];
      end else if (op == 3'd7) begin
        field = 5'(int'(rand_bits(5)) % 31); // LDI 31 would read as HLT
      end
      prog[i] = {op, field};
    end
  endtask

  task automatic run_model(output int steps);
    logic [4:0] pc;
    logic [7:0] insn;
    logic [7:0] imm;
    model_mem = prog;
    model_acc = '0;
    pc = '0;
    steps = 0;
    while (model_mem[pc] != `ACC_HALT_INSN) begin
      insn = model_mem[pc];
      imm = {3'b000, insn[4:0]};
      pc = pc + 5'd1;
      steps++;
      case (insn[7:5])
        3'd0: model_acc = model_mem[insn[4:0]];
        3'd1: model_mem[insn[4:0]] = model_acc;
        3'd2: pc = insn[4:0];
        3'd3: begin
          if (model_acc == 8'd0) begin
            pc = insn[4:0];
            jz_taken++;
          end else begin
            jz_skipped++;
          end
        end
        3'd4: model_acc = model_acc + model_mem[insn[4:0]];
        3'd5: model_acc = model_acc - model_mem[insn[4:0]];
        3'd6: model_acc = alu_model(insn[4:1], model_acc, imm); // Operand is the low five bits
        default: model_acc = imm;
      endcase
    end
  endtask

  task automatic peek(input logic [`ACC_ADDR_W-1:0] addr, output logic [`ACC_DATA_W-1:0] data);
    peek_addr = addr;
    #1;
    data = peek_data;
  endtask

  task automatic load_program();
    for (int a = 0; a < `ACC_MEM_DEPTH; a++) begin
      load_addr = 5'(a);
      load_data = prog[a];
      load_enable = 1'b1;
      @(posedge clk);
      #2;
    end
    load_enable = 1'b0;
  endtask

  task automatic run_program(input int steps, input logic stalls);
    int         enabled;
    logic       stall;
    logic [4:0] pa;
    logic [7:0] acc_before;
    logic [7:0] mem_before;
    logic [7:0] mem_after;
    enabled = 0;
    while (enabled < 2 * steps + 5) begin
      stall = stalls && (rand_bits(2) == 8'd0);
      processor_enable = !stall;
      pa = 5'(rand_bits(5));
      acc_before = acc_value;
      peek(pa, mem_before);
      @(posedge clk);
      #2;
      if (stall) begin
        check_byte("stalled acc", acc_before, acc_value);
        peek(pa, mem_after);
        check_byte("stalled memory", mem_before, mem_after);
      end else begin
        enabled++;
        check_bit("halt timing", enabled >= 2 * steps + 2, processor_halted);
        if (enabled > 2 * steps + 2) begin
          check_byte("acc held in halt", acc_before, acc_value);
        end
      end
    end
    processor_enable = 1'b0;
  endtask

  task automatic check_results();
    logic [7:0] got;
    check_byte("final acc", model_acc, acc_value);
    for (int a = 0; a < `ACC_MEM_DEPTH; a++) begin
      peek(5'(a), got);
      check_byte($sformatf("final memory[%0d]", a), model_mem[a], got);
    end
  endtask

  // HALT shifts out top bit first while the FETCH code shifts in
  task automatic scan_check();
    logic [2:0] halt_code;
    logic [2:0] fetch_code;
    logic [7:0] acc_hold;
    @(posedge clk);
    #2;
    halt_code = acc_cpu_ctrl_pkg::STATE_HALT;
    fetch_code = acc_cpu_ctrl_pkg::STATE_FETCH;
    acc_hold = acc_value;
    scan_enable = 1'b1;
    for (int i = 2; i >= 0; i--) begin
      check_bit("scan out", halt_code[i], scan_out);
      scan_in = fetch_code[i];
      @(posedge clk);
      #2;
    end
    scan_enable = 1'b0;
    scan_in = 1'b0;
    check_state("scanned state", acc_cpu_ctrl_pkg::STATE_FETCH, dut0.ctrl0.state);
    check_bit("halted after scan", 1'b0, processor_halted);
    processor_enable = 1'b1;
    @(posedge clk);
    #2;
    processor_enable = 1'b0;
    check_state("refetch of HLT", acc_cpu_ctrl_pkg::STATE_HALT, dut0.ctrl0.state); // PC is past HLT
    check_byte("acc after rescan", acc_hold, acc_value);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run("The run timed out before all programs finished");
  end

  initial begin
    rst = 1'b1;
    processor_enable = 1'b0;
    scan_enable = 1'b0;
    scan_in = 1'b0;
    load_enable = 1'b0;
    load_addr = '0;
    load_data = '0;
    peek_addr = '0;
    for (int p = 0; p < NUM_PROGS; p++) begin
      make_program();
      run_model(k);
      rst = 1'b1;
      load_program();
      repeat (8) @(posedge clk);
      #2;
      rst = 1'b0;
      run_program(k, p[0]); // Every other program runs with random stalls
      check_results();
      scan_check();
    end
    if (jz_taken == 0 || jz_skipped == 0) begin
      fail_run("The random programs never took JZ both ways");
    end else if (dut0.assert0.fail_count != 0) begin
      fail_run("A bound assertion failed during the run");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// File: acc_cpu_assert.sv
`timescale 1ns/1ps

module acc_cpu_assert (
  input logic                         clk,
  input logic                         rst,
  input logic                         processor_enable,
  input logic                         load_enable,
  input logic                         processor_halted,
  input acc_cpu_ctrl_pkg::ctrl_word_t ctrl,
  input acc_cpu_ctrl_pkg::cpu_state_e state
);

  logic        any_write;
  int unsigned fail_count = 0;

  assign any_write = ctrl.pc_write | ctrl.acc_write | ctrl.ir_load | ctrl.mem_write;

  quiet_when_stalled: assert property (@(posedge clk) !processor_enable |-> !any_write)
    else begin
      $error("A write enable is high while the processor is stalled");
      fail_count++;
    end

  halted_is_halt_state: assert property (@(posedge clk) disable iff (rst)
    processor_halted == (state == acc_cpu_ctrl_pkg::STATE_HALT))
    else begin
      $error("processor_halted does not follow the HALT state");
      fail_count++;
    end

  // Enable wins over scan in the state register, so an enabled EXECUTE always returns to FETCH
  execute_then_fetch: assert property (@(posedge clk) disable iff (rst)
    (state == acc_cpu_ctrl_pkg::STATE_EXECUTE && processor_enable)
    |=> state == acc_cpu_ctrl_pkg::STATE_FETCH)
    else begin
      $error("The state after EXECUTE is not FETCH");
      fail_count++;
    end

  no_load_while_running: assert property (@(posedge clk) !(load_enable && processor_enable))
    else begin
      $error("Memory load while the processor is enabled");
      fail_count++;
    end

endmodule

bind acc_cpu_top acc_cpu_assert assert0 (
  .clk             (clk),
  .rst             (rst),
  .processor_enable(processor_enable),
  .load_enable     (load_enable),
  .processor_halted(processor_halted),
  .ctrl            (ctrl),
  .state           (ctrl0.state)
);

// File: acc_cpu_top.sv
`timescale 1ns/1ps
`include "acc_cpu_consts.svh"

module acc_cpu_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   processor_enable,
  input  logic                   scan_enable,
  input  logic                   scan_in,
  input  logic                   load_enable,
  input  logic [`ACC_ADDR_W-1:0] load_addr,
  input  logic [`ACC_DATA_W-1:0] load_data,
  input  logic [`ACC_ADDR_W-1:0] peek_addr,
  output logic                   processor_halted,
  output logic                   scan_out,
  output logic [`ACC_DATA_W-1:0] peek_data,
  output logic [`ACC_DATA_W-1:0] acc_value
);

  acc_cpu_ctrl_pkg::ctrl_word_t ctrl;
  acc_cpu_isa_pkg::insn_t       ir;
  acc_cpu_isa_pkg::insn_t       fetch_word;
  logic                         zf;

  control_unit ctrl0 (
    .clk             (clk),
    .rst             (rst),
    .processor_enable(processor_enable),
    .scan_enable     (scan_enable),
    .scan_in         (scan_in),
    .scan_out        (scan_out),
    .processor_halted(processor_halted),
    .fetch_word      (fetch_word),
    .ir              (ir),
    .zf              (zf),
    .ctrl            (ctrl)
  );

  datapath dp0 (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .ir         (ir),
    .fetch_word (fetch_word),
    .zf         (zf),
    .acc_value  (acc_value),
    .load_enable(load_enable),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .peek_addr  (peek_addr),
    .peek_data  (peek_data)
  );

endmodule

// File: datapath.sv
`timescale 1ns/1ps
`include "acc_cpu_consts.svh"

module datapath (
  input  logic                         clk,
  input  logic                         rst,
  input  acc_cpu_ctrl_pkg::ctrl_word_t ctrl,
  output acc_cpu_isa_pkg::insn_t       ir,
  output acc_cpu_isa_pkg::insn_t       fetch_word,
  output logic                         zf,
  output logic [`ACC_DATA_W-1:0]       acc_value,
  input  logic                         load_enable,
  input  logic [`ACC_ADDR_W-1:0]       load_addr,
  input  logic [`ACC_DATA_W-1:0]       load_data,
  input  logic [`ACC_ADDR_W-1:0]       peek_addr,
  output logic [`ACC_DATA_W-1:0]       peek_data
);

  localparam logic [`ACC_ADDR_W-1:0] PC_STEP = 1;

  logic [`ACC_ADDR_W-1:0] pc_q;
  logic [`ACC_ADDR_W-1:0] pc_next;
  logic [`ACC_ADDR_W-1:0] mem_addr;
  logic [`ACC_DATA_W-1:0] acc_q;
  logic [`ACC_DATA_W-1:0] acc_next;
  logic [`ACC_DATA_W-1:0] mem_rdata;
  logic [`ACC_DATA_W-1:0] imm_ext;
  logic [`ACC_DATA_W-1:0] alu_b;
  logic [`ACC_DATA_W-1:0] alu_result;
  acc_cpu_isa_pkg::insn_t ir_q;

  assign imm_ext = {{(`ACC_DATA_W - `ACC_ADDR_W){1'b0}}, ir_q.addr_form.addr};

  assign mem_addr = (ctrl.mem_addr_sel == acc_cpu_ctrl_pkg::ADDR_INSN_ADDRESS) ?
                    ir_q.addr_form.addr : pc_q;

  assign alu_b = (ctrl.alu_b_sel == acc_cpu_ctrl_pkg::B_IMMEDIATE) ? imm_ext : mem_rdata;

  always_comb begin
    case (ctrl.pc_sel)
      acc_cpu_ctrl_pkg::PC_INCREMENT:   pc_next = pc_q + PC_STEP;
      acc_cpu_ctrl_pkg::PC_JUMP_TARGET: pc_next = ir_q.addr_form.addr;
      default:                          pc_next = pc_q;
    endcase
  end

  always_comb begin
    case (ctrl.acc_sel)
      acc_cpu_ctrl_pkg::ACC_ALU_RESULT: acc_next = alu_result;
      acc_cpu_ctrl_pkg::ACC_MEMORY:     acc_next = mem_rdata;
      acc_cpu_ctrl_pkg::ACC_IMMEDIATE:  acc_next = imm_ext;
      default:                          acc_next = acc_q;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q  <= '0;
      ir_q  <= '0;
      acc_q <= '0;
    end else begin
      if (ctrl.pc_write) begin
        pc_q <= pc_next;
      end
      if (ctrl.ir_load) begin
        ir_q <= acc_cpu_isa_pkg::insn_t'(mem_rdata);
      end
      if (ctrl.acc_write) begin
        acc_q <= acc_next;
      end
    end
  end

  alu alu0 (
    .op    (ctrl.alu_op),
    .a     (acc_q),
    .b     (alu_b),
    .result(alu_result)
  );

  data_memory mem0 (
    .clk        (clk),
    .addr       (mem_addr),
    .wdata      (acc_q),
    .write      (ctrl.mem_write),
    .rdata      (mem_rdata),
    .load_enable(load_enable),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .peek_addr  (peek_addr),
    .peek_data  (peek_data)
  );

  assign fetch_word = acc_cpu_isa_pkg::insn_t'(mem_rdata); // Word at PC during FETCH
  assign ir         = ir_q;
  assign zf         = (acc_q == '0);
  assign acc_value  = acc_q;

endmodule

// File: data_memory.sv
`timescale 1ns/1ps
`include "acc_cpu_consts.svh"

module data_memory (
  input  logic                   clk,
  input  logic [`ACC_ADDR_W-1:0] addr,
  input  logic [`ACC_DATA_W-1:0] wdata,
  input  logic                   write,
  output logic [`ACC_DATA_W-1:0] rdata,
  input  logic                   load_enable,
  input  logic [`ACC_ADDR_W-1:0] load_addr,
  input  logic [`ACC_DATA_W-1:0] load_data,
  input  logic [`ACC_ADDR_W-1:0] peek_addr,
  output logic [`ACC_DATA_W-1:0] peek_data
);

  logic [`ACC_DATA_W-1:0] mem [`ACC_MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (load_enable) begin
      mem[load_addr] <= load_data; // Program load wins over the CPU
    end else if (write) begin
      mem[addr] <= wdata;
    end
  end

  assign rdata     = mem[addr];
  assign peek_data = mem[peek_addr];

endmodule

// File: alu.sv
`timescale 1ns/1ps
`include "acc_cpu_consts.svh"

module alu (
  input  acc_cpu_isa_pkg::alu_op_e  op,
  input  logic [`ACC_DATA_W-1:0]    a,
  input  logic [`ACC_DATA_W-1:0]    b,
  output logic [`ACC_DATA_W-1:0]    result
);

  localparam logic [`ACC_DATA_W-1:0] ONE = 1;

  // Everything wraps at the word width, no carry is kept
  always_comb begin
    case (op)
      acc_cpu_isa_pkg::ALU_PASS_B: result = b;
      acc_cpu_isa_pkg::ALU_ADD:    result = a + b;
      acc_cpu_isa_pkg::ALU_SUB:    result = a - b;
      acc_cpu_isa_pkg::ALU_NOT:    result = ~a;
      acc_cpu_isa_pkg::ALU_SHL:    result = {a[`ACC_DATA_W-2:0], 1'b0};
      acc_cpu_isa_pkg::ALU_SHR:    result = {1'b0, a[`ACC_DATA_W-1:1]};
      acc_cpu_isa_pkg::ALU_INC:    result = a + ONE;
      acc_cpu_isa_pkg::ALU_DEC:    result = a - ONE;
      acc_cpu_isa_pkg::ALU_CLR:    result = '0;
      default:                     result = a; // Unused codes leave ACC as it is
    endcase
  end

endmodule

// File: control_unit.sv
`timescale 1ns/1ps
`include "acc_cpu_consts.svh"

module control_unit (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         processor_enable,
  input  logic                         scan_enable,
  input  logic                         scan_in,
  output logic                         scan_out,
  output logic                         processor_halted,
  input  acc_cpu_isa_pkg::insn_t       fetch_word,
  input  acc_cpu_isa_pkg::insn_t       ir,
  input  logic                         zf,
  output acc_cpu_ctrl_pkg::ctrl_word_t ctrl
);

  logic [2:0]                   state_q;
  logic [2:0]                   next_state;
  acc_cpu_ctrl_pkg::cpu_state_e state;
  acc_cpu_ctrl_pkg::ctrl_word_t ctrl_raw;

  scan_state_reg #(
    .WIDTH(3)
  ) state_register (
    .clk        (clk),
    .rst        (rst),
    .enable     (processor_enable),
    .d          (next_state),
    .q          (state_q),
    .scan_enable(scan_enable),
    .scan_in    (scan_in),
    .scan_out   (scan_out)
  );

  assign state = acc_cpu_ctrl_pkg::cpu_state_e'(state_q);

  always_comb begin
    next_state = state_q;
    case (state)
      acc_cpu_ctrl_pkg::STATE_RESET: next_state = acc_cpu_ctrl_pkg::STATE_FETCH;
      acc_cpu_ctrl_pkg::STATE_FETCH: begin
        if (fetch_word == `ACC_HALT_INSN) begin
          next_state = acc_cpu_ctrl_pkg::STATE_HALT;
        end else begin
          next_state = acc_cpu_ctrl_pkg::STATE_EXECUTE;
        end
      end
      acc_cpu_ctrl_pkg::STATE_EXECUTE: next_state = acc_cpu_ctrl_pkg::STATE_FETCH;
      acc_cpu_ctrl_pkg::STATE_HALT: next_state = acc_cpu_ctrl_pkg::STATE_HALT;
      default: next_state = acc_cpu_ctrl_pkg::STATE_FETCH; // Recover from a scanned-in junk code
    endcase
  end

  always_comb begin
    ctrl_raw.pc_write     = 1'b0;
    ctrl_raw.pc_sel       = acc_cpu_ctrl_pkg::PC_INCREMENT;
    ctrl_raw.acc_write    = 1'b0;
    ctrl_raw.acc_sel      = acc_cpu_ctrl_pkg::ACC_ALU_RESULT;
    ctrl_raw.ir_load      = 1'b0;
    ctrl_raw.alu_op       = acc_cpu_isa_pkg::ALU_PASS_B;
    ctrl_raw.alu_b_sel    = acc_cpu_ctrl_pkg::B_MEMORY;
    ctrl_raw.mem_write    = 1'b0;
    ctrl_raw.mem_addr_sel = acc_cpu_ctrl_pkg::ADDR_PROGRAM_COUNTER;
    case (state)
      acc_cpu_ctrl_pkg::STATE_FETCH: begin
        ctrl_raw.ir_load  = 1'b1;
        ctrl_raw.pc_write = 1'b1;
      end
      acc_cpu_ctrl_pkg::STATE_EXECUTE: begin
        ctrl_raw.mem_addr_sel = acc_cpu_ctrl_pkg::ADDR_INSN_ADDRESS;
        case (ir.addr_form.opcode)
          acc_cpu_isa_pkg::OP_LDA: begin
            ctrl_raw.acc_write = 1'b1;
            ctrl_raw.acc_sel   = acc_cpu_ctrl_pkg::ACC_MEMORY;
          end
          acc_cpu_isa_pkg::OP_STA: ctrl_raw.mem_write = 1'b1;
          acc_cpu_isa_pkg::OP_JMP: begin
            ctrl_raw.pc_write = 1'b1;
            ctrl_raw.pc_sel   = acc_cpu_ctrl_pkg::PC_JUMP_TARGET;
          end
          acc_cpu_isa_pkg::OP_JZ: begin
            ctrl_raw.pc_write = zf; // Not taken leaves PC past the JZ
            ctrl_raw.pc_sel   = acc_cpu_ctrl_pkg::PC_JUMP_TARGET;
          end
          acc_cpu_isa_pkg::OP_ADD: begin
            ctrl_raw.acc_write = 1'b1;
            ctrl_raw.alu_op    = acc_cpu_isa_pkg::ALU_ADD;
          end
          acc_cpu_isa_pkg::OP_SUB: begin
            ctrl_raw.acc_write = 1'b1;
            ctrl_raw.alu_op    = acc_cpu_isa_pkg::ALU_SUB;
          end
          acc_cpu_isa_pkg::OP_ALU: begin
            // PASS_B here loads the low five insn bits, zero-extended
            ctrl_raw.acc_write = 1'b1;
            ctrl_raw.alu_op    = ir.alu_form.op;
            ctrl_raw.alu_b_sel = acc_cpu_ctrl_pkg::B_IMMEDIATE;
          end
          acc_cpu_isa_pkg::OP_LDI: begin
            ctrl_raw.acc_write = 1'b1;
            ctrl_raw.acc_sel   = acc_cpu_ctrl_pkg::ACC_IMMEDIATE;
          end
          default: ctrl_raw.acc_write = 1'b0;
        endcase
      end
      default: ctrl_raw.ir_load = 1'b0; // RESET and HALT stay quiet
    endcase
  end

  // A stalled cycle must not touch PC, IR, ACC or memory
  always_comb begin
    ctrl           = ctrl_raw;
    ctrl.pc_write  = ctrl_raw.pc_write & processor_enable;
    ctrl.acc_write = ctrl_raw.acc_write & processor_enable;
    ctrl.ir_load   = ctrl_raw.ir_load & processor_enable;
    ctrl.mem_write = ctrl_raw.mem_write & processor_enable;
  end

  assign processor_halted = (state == acc_cpu_ctrl_pkg::STATE_HALT);

endmodule

// File: scan_state_reg.sv
`timescale 1ns/1ps

module scan_state_reg #(
  parameter int WIDTH = 3
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             enable,
  input  logic [WIDTH-1:0] d,
  output logic [WIDTH-1:0] q,
  input  logic             scan_enable,
  input  logic             scan_in,
  output logic             scan_out
);

  logic [WIDTH-1:0] state_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= '0;
    end else if (enable) begin
      state_q <= d;
    end else if (scan_enable) begin
      state_q <= {state_q[WIDTH-2:0], scan_in}; // Shift toward the MSB
    end
  end

  assign q        = state_q;
  assign scan_out = state_q[WIDTH-1];

endmodule

// File: acc_cpu_ctrl_pkg.sv
package acc_cpu_ctrl_pkg;

  typedef enum logic [2:0] {
    STATE_RESET   = 3'b000,
    STATE_FETCH   = 3'b001,
    STATE_EXECUTE = 3'b010,
    STATE_HALT    = 3'b100
  } cpu_state_e;

  typedef enum logic [1:0] {
    PC_INCREMENT   = 2'd0,
    PC_JUMP_TARGET = 2'd1
  } pc_sel_e;

  typedef enum logic [1:0] {
    ACC_ALU_RESULT = 2'd0,
    ACC_MEMORY     = 2'd1,
    ACC_IMMEDIATE  = 2'd2
  } acc_sel_e;

  typedef enum logic {
    ADDR_PROGRAM_COUNTER = 1'b0,
    ADDR_INSN_ADDRESS    = 1'b1
  } addr_sel_e;

  typedef enum logic {
    B_MEMORY    = 1'b0,
    B_IMMEDIATE = 1'b1
  } alu_b_sel_e;

  typedef struct packed {
    logic                      pc_write;
    pc_sel_e                   pc_sel;
    logic                      acc_write;
    acc_sel_e                  acc_sel;
    logic                      ir_load;
    acc_cpu_isa_pkg::alu_op_e  alu_op;
    alu_b_sel_e                alu_b_sel;
    logic                      mem_write;
    addr_sel_e                 mem_addr_sel;
  } ctrl_word_t;

endpackage

// File: acc_cpu_isa_pkg.sv
`include "acc_cpu_consts.svh"

package acc_cpu_isa_pkg;

  typedef enum logic [`ACC_OPCODE_W-1:0] {
    OP_LDA = 3'd0, // acc <= mem[a]
    OP_STA = 3'd1, // mem[a] <= acc
    OP_JMP = 3'd2,
    OP_JZ  = 3'd3,
    OP_ADD = 3'd4, // acc <= acc + mem[a]
    OP_SUB = 3'd5, // acc <= acc - mem[a]
    OP_ALU = 3'd6, // Register only, op in bits 4:1
    OP_LDI = 3'd7  // acc <= zero-extended imm5
  } opcode_e;

  typedef enum logic [`ACC_ALU_OP_W-1:0] {
    ALU_PASS_B = 4'd0,
    ALU_ADD    = 4'd1,
    ALU_SUB    = 4'd2,
    ALU_NOT    = 4'd3,
    ALU_SHL    = 4'd4,
    ALU_SHR    = 4'd5,
    ALU_INC    = 4'd6,
    ALU_DEC    = 4'd7,
    ALU_CLR    = 4'd8
  } alu_op_e;

  typedef struct packed {
    opcode_e                 opcode;
    logic [`ACC_ADDR_W-1:0]  addr; // Address or immediate
  } addr_form_t;

  typedef struct packed {
    opcode_e opcode;
    alu_op_e op;
    logic    spare;
  } alu_form_t;

  // Same byte, seen as a memory/immediate form or as an ALU form
  typedef union packed {
    addr_form_t addr_form;
    alu_form_t  alu_form;
  } insn_t;

endpackage

// File: acc_cpu_consts.svh
`ifndef ACC_CPU_CONSTS_SVH
`define ACC_CPU_CONSTS_SVH

// Accumulator and memory word width
`define ACC_DATA_W 8

// Program counter and memory address width
`define ACC_ADDR_W 5

`define ACC_MEM_DEPTH 32

// Instruction field widths
`define ACC_OPCODE_W 3
`define ACC_ALU_OP_W 4

// All ones stops the machine
`define ACC_HALT_INSN {`ACC_DATA_W{1'b1}}

`endif
